/* conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// one byte per SRAM bank
`define CONV_PIX_W      8
`define CONV_CHANNELS   16

// 4x4 scanned area around the 2x2 output block
`define CONV_SCAN_W     4

// 3x3 kernel
`define CONV_KSIZE      3
`define CONV_TAPS       9

// two scan rows plus three taps of the current row
`define CONV_LB_DEPTH   11

// full channel sum, dropped fraction bits and rounded output
`define CONV_SUM_W      18
`define CONV_FRAC_W     4
`define CONV_RES_W      14

`define CONV_IDX_W      4

// compute counts where the line buffer holds a complete window
`define CONV_OUT_CYC0   12
`define CONV_OUT_CYC1   13
`define CONV_OUT_CYC2   16
`define CONV_OUT_CYC3   17

`define CONV_LAST_CYC   18

`endif

/* conv_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_pkg;

    // single SRAM byte
    typedef logic [`CONV_PIX_W-1:0] pixel_t;

    // one byte from every bank in the same cycle
    typedef pixel_t [`CONV_CHANNELS-1:0] chan_pixels_t;

    // kernel taps per channel, index 0 is top-left, index 8 is bottom-right
    typedef pixel_t [`CONV_CHANNELS-1:0][`CONV_TAPS-1:0] tap_window_t;

    // weighted 3x3 sum of one channel, 255 * 16 at most
    typedef logic [`CONV_PIX_W+3:0] chan_sum_t;

    // sum over all selected channels, still with 4 fraction bits
    typedef logic [`CONV_SUM_W-1:0] conv_sum_t;

    typedef logic [`CONV_RES_W-1:0] conv_result_t;

    // number of channels added into each result
    typedef enum logic {
        WIN_8CH  = 1'b0,
        WIN_16CH = 1'b1
    } chan_window_t;

    // x or y position in the SRAM image
    typedef logic [`CONV_IDX_W-1:0] idx_t;

endpackage

`default_nettype wire

/* conv_line_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_consts.svh"

module conv_line_buffer
    import conv_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_rst_n,
    input  wire logic         i_shift,
    input  wire chan_pixels_t i_sram_data,
    output tap_window_t       o_window
);

    // tap 0 holds the newest byte
    pixel_t line_q [`CONV_CHANNELS][`CONV_LB_DEPTH];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                for (int t = 0; t < `CONV_LB_DEPTH; t++) begin
                    line_q[ch][t] <= '0;
                end
            end
        end else if (i_shift) begin
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                line_q[ch][0] <= i_sram_data[ch];
                for (int t = 1; t < `CONV_LB_DEPTH; t++) begin
                    line_q[ch][t] <= line_q[ch][t-1];
                end
            end
        end
    end

    // kernel row r and column c sit (2-r) scan rows and (2-c) pixels behind tap 0
    for (genvar ch = 0; ch < `CONV_CHANNELS; ch++) begin : g_chan
        for (genvar k = 0; k < `CONV_TAPS; k++) begin : g_tap
            localparam int ROW = k / `CONV_KSIZE;
            localparam int COL = k % `CONV_KSIZE;
            localparam int TAP = (`CONV_KSIZE - 1 - ROW) * `CONV_SCAN_W
                               + (`CONV_KSIZE - 1 - COL);
            assign o_window[ch][k] = line_q[ch][TAP];
        end
    end

endmodule

`default_nettype wire

/* conv_kernel_sum.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_consts.svh"

module conv_kernel_sum
    import conv_pkg::*;
(
    input  wire tap_window_t  i_window,
    input  wire chan_window_t i_channel_window,
    output conv_result_t      o_result
);

    localparam int HALF = `CONV_CHANNELS / 2;

    // kernel weights in sixteenths: corner 1, edge 2, centre 4
    function automatic chan_sum_t chan_weighted_sum(input pixel_t [`CONV_TAPS-1:0] taps);
        chan_sum_t acc;
        int        shamt;
        acc = '0;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            shamt = ((k / `CONV_KSIZE) == 1) + ((k % `CONV_KSIZE) == 1);
            acc = acc + (chan_sum_t'(taps[k]) << shamt);
        end
        return acc;
    endfunction

    // pairwise reduction, log2(HALF) adder levels
    function automatic conv_sum_t tree_sum(input chan_sum_t [HALF-1:0] leaves);
        conv_sum_t node [HALF];
        for (int i = 0; i < HALF; i++) begin
            node[i] = conv_sum_t'(leaves[i]);
        end
        for (int step = 1; step < HALF; step = step * 2) begin
            for (int i = 0; i < HALF; i = i + 2 * step) begin
                node[i] = node[i] + node[i+step];
            end
        end
        return node[0];
    endfunction

    chan_sum_t [`CONV_CHANNELS-1:0] chan_sum;
    conv_sum_t                      lo_sum;
    conv_sum_t                      hi_sum;
    conv_sum_t                      full_sum;
    logic                           round_up;

    for (genvar ch = 0; ch < `CONV_CHANNELS; ch++) begin : g_chan
        assign chan_sum[ch] = chan_weighted_sum(i_window[ch]);
    end

    assign lo_sum = tree_sum(chan_sum[HALF-1:0]);
    assign hi_sum = tree_sum(chan_sum[`CONV_CHANNELS-1:HALF]);

    // upper eight channels only join the sum in the 16-channel window
    assign full_sum = lo_sum + ((i_channel_window == WIN_16CH) ? hi_sum : '0);

    // half-up rounding, no increment when the integer part is already all ones
    assign round_up = full_sum[`CONV_FRAC_W-1]
                    && !(&full_sum[`CONV_SUM_W-2:`CONV_FRAC_W]);

    assign o_result = full_sum[`CONV_SUM_W-1:`CONV_FRAC_W] + conv_result_t'(round_up);

endmodule

`default_nettype wire

/* conv_scan_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_consts.svh"

module conv_scan_ctrl
    import conv_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_start,
    input  wire idx_t i_origin_x,
    input  wire idx_t i_origin_y,
    output logic      o_ready,
    output logic      o_finished,
    output idx_t      o_mem_x_index,
    output idx_t      o_mem_y_index,
    output logic      o_shift,
    output logic      o_output_valid
);

    localparam int CNT_W = $clog2(`CONV_LAST_CYC + 1);

    typedef enum logic [1:0] {
        ST_START,
        ST_IDLE,
        ST_COMPUTE,
        ST_FINISH
    } state_t;

    state_t           state;
    state_t           state_nxt;
    logic [CNT_W-1:0] cycle_cnt;
    idx_t             x_cnt;
    idx_t             y_cnt;
    idx_t             x_first;
    idx_t             y_first;
    idx_t             x_last;
    idx_t             y_last;
    logic             accept;
    logic             computing;
    logic             last_cyc;
    logic             out_cyc;

    // scan corners, 4-bit wraparound
    assign x_first = i_origin_x - idx_t'(1);
    assign y_first = i_origin_y - idx_t'(1);
    assign x_last  = i_origin_x + idx_t'(2);
    assign y_last  = i_origin_y + idx_t'(2);

    assign accept    = (state == ST_IDLE) && i_start;
    assign computing = (state == ST_COMPUTE);
    assign last_cyc  = (cycle_cnt == CNT_W'(`CONV_LAST_CYC));

    // counts where a full window has been shifted in
    assign out_cyc = (cycle_cnt == CNT_W'(`CONV_OUT_CYC0))
                  || (cycle_cnt == CNT_W'(`CONV_OUT_CYC1))
                  || (cycle_cnt == CNT_W'(`CONV_OUT_CYC2))
                  || (cycle_cnt == CNT_W'(`CONV_OUT_CYC3));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_START: begin
                state_nxt = ST_IDLE;
            end
            ST_IDLE: begin
                if (i_start) begin
                    state_nxt = ST_COMPUTE;
                end
            end
            ST_COMPUTE: begin
                if (last_cyc) begin
                    state_nxt = ST_FINISH;
                end
            end
            ST_FINISH: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_START;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_START;
            cycle_cnt <= '0;
            x_cnt     <= '0;
            y_cnt     <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                cycle_cnt <= '0;
                x_cnt     <= x_first;
                y_cnt     <= y_first;
            end else if (computing) begin
                if (!last_cyc) begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
                // row-major walk, the final index holds until the job ends
                if (x_cnt != x_last) begin
                    x_cnt <= x_cnt + 1'b1;
                end else if (y_cnt != y_last) begin
                    x_cnt <= x_first;
                    y_cnt <= y_cnt + 1'b1;
                end
            end
        end
    end

    assign o_ready        = (state == ST_IDLE);
    assign o_finished     = (state == ST_FINISH);
    assign o_shift        = computing;
    assign o_output_valid = computing && out_cyc;

    // index port parks at zero outside compute
    assign o_mem_x_index = computing ? x_cnt : '0;
    assign o_mem_y_index = computing ? y_cnt : '0;

endmodule

`default_nettype wire

/* conv_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_consts.svh"

module conv_engine
    import conv_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_rst_n,
    input  wire logic         i_start,
    output logic              o_ready,
    output logic              o_finished,
    input  wire idx_t         i_origin_x,
    input  wire idx_t         i_origin_y,
    input  wire chan_window_t i_channel_window,
    output idx_t              o_mem_x_index,
    output idx_t              o_mem_y_index,
    input  wire chan_pixels_t i_sram_data,
    output logic              o_output_valid,
    output conv_result_t      o_output_data
);

    logic        shift;
    tap_window_t window;

    // schedule of reads, shifts and output strobes
    conv_scan_ctrl conv_scan_ctrl_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_origin_x     (i_origin_x),
        .i_origin_y     (i_origin_y),
        .o_ready        (o_ready),
        .o_finished     (o_finished),
        .o_mem_x_index  (o_mem_x_index),
        .o_mem_y_index  (o_mem_y_index),
        .o_shift        (shift),
        .o_output_valid (o_output_valid)
    );

    // SRAM data arrives one cycle after its index and is shifted in directly
    conv_line_buffer conv_line_buffer_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_shift     (shift),
        .i_sram_data (i_sram_data),
        .o_window    (window)
    );

    conv_kernel_sum conv_kernel_sum_inst (
        .i_window         (window),
        .i_channel_window (i_channel_window),
        .o_result         (o_output_data)
    );

endmodule

`default_nettype wire

/* conv_engine_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_engine_asserts (
    input wire logic i_clk,
    input wire logic i_rst_n,
    input wire logic i_start,
    input wire logic i_ready,
    input wire logic i_finished,
    input wire logic i_output_valid
);

    // set by an accepted start and cleared after the finish pulse
    logic job_active;

    // number of failed assertions
    int   assert_failures = 0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            job_active <= 1'b0;
        end else if (i_ready && i_start) begin
            job_active <= 1'b1;
        end else if (i_finished) begin
            job_active <= 1'b0;
        end
    end

    property finished_single_pulse;
        @(posedge i_clk) disable iff (!i_rst_n)
            i_finished |=> !i_finished;
    endproperty

    property valid_not_ready;
        @(posedge i_clk) disable iff (!i_rst_n)
            !(i_output_valid && i_ready);
    endproperty

    property busy_not_ready;
        @(posedge i_clk) disable iff (!i_rst_n)
            job_active |-> !i_ready;
    endproperty

    a_finished_single: assert property (finished_single_pulse)
        else begin
            $error("o_finished was high for two cycles in a row");
            assert_failures++;
        end

    a_valid_not_ready: assert property (valid_not_ready)
        else begin
            $error("o_output_valid and o_ready were high together");
            assert_failures++;
        end

    a_busy_not_ready: assert property (busy_not_ready)
        else begin
            $error("o_ready rose before the job finished");
            assert_failures++;
        end

endmodule

`default_nettype wire

/* tb_conv_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "conv_consts.svh"

module tb_conv_engine
    import conv_pkg::*;
();

    // one stimulus line holds ox oy win base a b c spot_x spot_y spot_d hold exp0..exp3
    localparam int NUM_FIELDS = 15;
    localparam int MAX_TESTS  = 16;
    localparam int WAIT_LIMIT = 40;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic         ready;
    logic         finished;
    idx_t         origin_x;
    idx_t         origin_y;
    chan_window_t channel_window;
    idx_t         mem_x_index;
    idx_t         mem_y_index;
    chan_pixels_t sram_data;
    logic         output_valid;
    conv_result_t output_data;

    logic [15:0]  stim_mem [NUM_FIELDS*MAX_TESTS];
    int           job_base;
    int           job_a;
    int           job_b;
    int           job_c;
    int           spot_x;
    int           spot_y;
    int           spot_d;
    idx_t         prev_x;
    idx_t         prev_y;
    int           error_count;
    int           pass_count;
    int           fail_count;
    int           seed;

    conv_engine conv_engine_inst (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_start          (start),
        .o_ready          (ready),
        .o_finished       (finished),
        .i_origin_x       (origin_x),
        .i_origin_y       (origin_y),
        .i_channel_window (channel_window),
        .o_mem_x_index    (mem_x_index),
        .o_mem_y_index    (mem_y_index),
        .i_sram_data      (sram_data),
        .o_output_valid   (output_valid),
        .o_output_data    (output_data)
    );

    bind conv_engine conv_engine_asserts conv_engine_asserts_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_ready        (o_ready),
        .i_finished     (o_finished),
        .i_output_valid (o_output_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // linear pattern plus one optional spot in channel 0
    function automatic int pixel_value(int ch, int x, int y);
        int v;
        v = job_base + job_a * ch + job_b * x + job_c * y;
        if (ch == 0 && x == spot_x && y == spot_y) begin
            v = v + spot_d;
        end
        return v % 256;
    endfunction

    // 3x3 smoothing around the block position with weights in sixteenths
    function automatic int kernel_result(int ox, int oy, int nch, int pos);
        int cx;
        int cy;
        int wt;
        int acc;
        cx = ox + pos % 2;
        cy = oy + pos / 2;
        acc = 0;
        for (int ch = 0; ch < nch; ch++) begin
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    wt = (dx == 0 ? 2 : 1) * (dy == 0 ? 2 : 1);
                    acc = acc + wt * pixel_value(ch, (cx + dx) & 15, (cy + dy) & 15);
                end
            end
        end
        return (acc + 8) / 16;
    endfunction

    // errors from the checks here plus failed bound assertions
    function automatic int count_errors();
        return error_count + conv_engine_inst.conv_engine_asserts_inst.assert_failures;
    endfunction

    // SRAM answers the index of the previous cycle
    always @(negedge clk) begin
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            sram_data[ch] <= pixel_t'(pixel_value(ch, int'(prev_x), int'(prev_y)));
        end
        prev_x <= mem_x_index;
        prev_y <= mem_y_index;
    end

    task automatic report_mismatch(string what, int got, int expected);
        $display("** Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
        error_count++;
    endtask

    task automatic check_idle_outputs();
        assert (!output_valid) else report_mismatch("o_output_valid while idle", 1, 0);
        assert (!finished) else report_mismatch("o_finished while idle", 1, 0);
        assert (mem_x_index == '0 && mem_y_index == '0)
            else report_mismatch("index while idle as y*16+x",
                                 int'(mem_y_index) * 16 + int'(mem_x_index), 0);
    endtask

    task automatic wait_for_ready(output bit ok);
        int n;
        n = 0;
        while (!ready && n < WAIT_LIMIT) begin
            check_idle_outputs();
            @(negedge clk);
            n++;
        end
        ok = ready;
        if (!ok) begin
            $display("timeout: o_ready did not rise within %0d cycles", WAIT_LIMIT);
            error_count++;
        end
    endtask

    task automatic run_job(input int t, output bit ok);
        int   f;
        int   ox;
        int   oy;
        int   nch;
        int   cyc;
        int   step;
        int   n_out;
        int   expected;
        bit   hold;
        bit   done;
        bit   exp_valid;
        idx_t ex;
        idx_t ey;
        f = t * NUM_FIELDS;
        ox = int'(stim_mem[f]);
        oy = int'(stim_mem[f+1]);
        nch = (stim_mem[f+2] != 0) ? 16 : 8;
        job_base = int'(stim_mem[f+3]);
        job_a = int'(stim_mem[f+4]);
        job_b = int'(stim_mem[f+5]);
        job_c = int'(stim_mem[f+6]);
        spot_x = int'(stim_mem[f+7]);
        spot_y = int'(stim_mem[f+8]);
        spot_d = int'(stim_mem[f+9]);
        hold = (stim_mem[f+10] != 0);
        origin_x = idx_t'(ox);
        origin_y = idx_t'(oy);
        channel_window = (nch == 16) ? WIN_16CH : WIN_8CH;
        start = 1'b1;
        // ready is high here, so this edge accepts the job
        @(posedge clk);
        cyc = 0;
        n_out = 0;
        done = 1'b0;
        while (!done && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            cyc++;
            if (!hold) begin
                start = 1'b0;
            end
            assert (!ready) else report_mismatch($sformatf("o_ready in cycle %0d", cyc), 1, 0);
            if (cyc <= 19) begin
                // row-major walk from origin-1 where the last index holds after cycle 16
                step = (cyc - 1 < 15) ? cyc - 1 : 15;
                ex = idx_t'(ox - 1 + step % 4);
                ey = idx_t'(oy - 1 + step / 4);
                assert (mem_x_index == ex && mem_y_index == ey)
                    else report_mismatch($sformatf("index in cycle %0d as y*16+x", cyc),
                                         int'(mem_y_index) * 16 + int'(mem_x_index),
                                         int'(ey) * 16 + int'(ex));
            end
            exp_valid = (cyc == 13 || cyc == 14 || cyc == 17 || cyc == 18);
            assert (output_valid == exp_valid)
                else report_mismatch($sformatf("o_output_valid in cycle %0d", cyc),
                                     int'(output_valid), int'(exp_valid));
            if (output_valid && n_out < 4) begin
                expected = kernel_result(ox, oy, nch, n_out);
                assert (int'(stim_mem[f+11+n_out]) == expected)
                    else report_mismatch("result in stimulus file",
                                         int'(stim_mem[f+11+n_out]), expected);
                assert (int'(output_data) == expected)
                    else report_mismatch($sformatf("o_output_data for block position %0d", n_out),
                                         int'(output_data), expected);
                n_out++;
            end
            if (finished) begin
                done = 1'b1;
                assert (cyc == 20) else report_mismatch("cycle of o_finished", cyc, 20);
            end
        end
        if (!done) begin
            $display("timeout: o_finished did not come within %0d cycles of start", WAIT_LIMIT);
            error_count++;
        end else begin
            @(negedge clk);
            assert (ready) else report_mismatch("o_ready in the cycle after o_finished", 0, 1);
            check_idle_outputs();
        end
        ok = done;
    endtask

    initial begin
        int  t;
        int  errors_before;
        int  jitter;
        bit  ok;
        rst_n = 1'b0;
        start = 1'b0;
        origin_x = '0;
        origin_y = '0;
        channel_window = WIN_8CH;
        sram_data = '0;
        prev_x = '0;
        prev_y = '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        seed = 46992;
        // all ones marks the end of the stimulus
        for (int i = 0; i < NUM_FIELDS * MAX_TESTS; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("conv_stimulus.txt", stim_mem);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // start-up state keeps o_ready low until the first edge out of reset
        assert (!ready) else report_mismatch("o_ready in the start-up cycle", 1, 0);
        t = 0;
        ok = 1'b1;
        while (ok && t < MAX_TESTS && stim_mem[t*NUM_FIELDS] != 16'hffff) begin
            errors_before = count_errors();
            wait_for_ready(ok);
            if (ok) begin
                run_job(t, ok);
            end
            if (count_errors() == errors_before) begin
                pass_count++;
                $display("test %0d passed", t);
            end else begin
                fail_count++;
                $display("test %0d failed with %0d errors", t, count_errors() - errors_before);
            end
            // a held start goes straight into the next job
            if (ok && stim_mem[t*NUM_FIELDS+10] == 0) begin
                jitter = $random(seed) & 3;
                for (int j = 0; j < jitter; j++) begin
                    check_idle_outputs();
                    @(negedge clk);
                end
            end
            t++;
        end
        start = 1'b0;
        if (t == 0) begin
            $display("no tests were read from conv_stimulus.txt");
            error_count++;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 t, pass_count, fail_count, count_errors());
        if (count_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* conv_stimulus.txt */
// hex: ox oy win base a b c spot_x spot_y spot_d hold, then results (0,0) (1,0) (0,1) (1,1)
// pixel = (base + a*ch + b*x + c*y, plus spot_d in channel 0 at spot_x/spot_y) mod 256
5 6 0 0a 3 2 1 0 0 00 0 124 134 12c 13c
5 6 1 0a 3 2 1 0 0 00 0 308 328 318 338
8 3 0 00 f 1 1 0 0 00 0 1fc 204 204 20c
8 3 1 00 f 1 1 0 0 00 0 7b8 7c8 7c8 7d8
// spot fraction 8/16 rounds up, 7/16 truncates
2 2 0 14 1 1 1 1 1 08 0 0dd 0e4 0e4 0ec
2 2 0 14 1 1 1 1 1 07 1 0dc 0e4 0e4 0ec
2 2 1 14 1 1 1 3 2 0c 0 1fa 20b 209 21a
// index wraparound at origin 0 and at the top of the range
0 0 0 00 0 1 0 0 0 00 0 020 008 020 008
e f 1 c8 0 0 5 0 0 00 0 3f0 3f0 9c0 9c0
3 9 1 ff 0 0 0 0 0 00 0 ff0 ff0 ff0 ff0

/* vlog.f */
+incdir+.
conv_pkg.sv
conv_line_buffer.sv
conv_kernel_sum.sv
conv_scan_ctrl.sv
conv_engine.sv
conv_engine_asserts.sv
tb_conv_engine.sv

/* run_sim.sh */
#!/bin/sh
# build and run the conv_engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_conv_engine -o sim_conv_engine

./obj_dir/sim_conv_engine | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
